// File: src/nts_tx_pkg.sv
`default_nettype none

package nts_tx_pkg;

  // Bytes carried by one buffer word
  localparam int WORD_BYTES = 8;

  // Life cycle of one packet bank
  typedef enum logic [1:0] {
    BANK_EMPTY    = 2'd0,
    BANK_HAS_DATA = 2'd1,
    BANK_FIFO_OUT = 2'd2
  } bank_state_e;

  // Parser strobes, already routed to the parser bank
  typedef struct packed {
    logic        write_en;
    logic [63:0] write_data;
    logic        read_en;
    logic        update_length;
    logic        done;
    logic        clear;
  } parser_cmd_t;

  // Strobes towards the bank acting as FIFO
  typedef struct packed {
    logic rd_en;
    logic packet_read;
    logic start;
  } dispatch_cmd_t;

  // What each bank reports back
  typedef struct packed {
    bank_state_e state;
    logic        full;
    logic        fifo_empty;
    logic [3:0]  bytes_last_word;
    logic [63:0] fifo_data;
    logic [63:0] read_data;
  } bank_status_t;

endpackage

`default_nettype wire

// File: src/tx_bank.sv
`timescale 1ns/100ps
`default_nettype none

module tx_bank #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                            i_clk,
  input  wire                            i_areset,
  input  wire nts_tx_pkg::parser_cmd_t   i_parser_cmd,
  input  wire nts_tx_pkg::dispatch_cmd_t i_dispatch_cmd,
  input  wire [ADDR_WIDTH-1:0]           i_address_hi,
  input  wire [ADDR_WIDTH+2:0]           i_length,
  output nts_tx_pkg::bank_status_t       o_status
);

  localparam int BYTE_BITS = $clog2(nts_tx_pkg::WORD_BYTES);
  localparam int DEPTH     = 2 ** ADDR_WIDTH;

  //----------------------------------------
  // Storage and state
  //----------------------------------------

  logic [63:0] mem [0:DEPTH-1];

  nts_tx_pkg::bank_state_e state;

  // One extra bit so a completely filled bank can be told apart
  logic [ADDR_WIDTH:0]   wr_ptr;
  logic [ADDR_WIDTH:0]   rd_ptr;
  logic [ADDR_WIDTH:0]   word_count;
  logic [3:0]            bytes_last_word;
  logic [63:0]           read_data;

  logic                  full;
  logic                  fifo_empty;
  logic                  write_ok;
  logic [ADDR_WIDTH+3:0] length_round;
  logic [ADDR_WIDTH:0]   length_words;
  logic [BYTE_BITS-1:0]  length_rem;
  logic [3:0]            length_bytes;

  assign full = ((state == nts_tx_pkg::BANK_HAS_DATA) && wr_ptr[ADDR_WIDTH]) ||
                (state == nts_tx_pkg::BANK_FIFO_OUT);

  assign fifo_empty = (rd_ptr == word_count);

  assign write_ok = i_parser_cmd.write_en && !i_parser_cmd.clear && !full;

  // Length in bytes to word count and bytes in the last word
  always_comb begin
    length_round = {1'b0, i_length} + (ADDR_WIDTH + 4)'(nts_tx_pkg::WORD_BYTES - 1);
    length_words = length_round[ADDR_WIDTH+3:BYTE_BITS];
    length_rem   = i_length[BYTE_BITS-1:0];
    if (length_rem != '0) begin
      length_bytes = 4'(length_rem);
    end else if (i_length != '0) begin
      length_bytes = 4'(nts_tx_pkg::WORD_BYTES);
    end else begin
      length_bytes = 4'd0;
    end
  end

  // Word array
  always_ff @(posedge i_clk) begin
    if (write_ok) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= i_parser_cmd.write_data;
    end
  end

  //----------------------------------------
  // Control registers
  //----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state           <= nts_tx_pkg::BANK_EMPTY;
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      word_count      <= '0;
      bytes_last_word <= '0;
      read_data       <= '0;
    end else begin
      // Read-back word is only valid for one cycle
      read_data <= '0;

      if (i_parser_cmd.clear) begin
        state      <= nts_tx_pkg::BANK_EMPTY;
        wr_ptr     <= '0;
        word_count <= '0;
      end else begin
        if (write_ok) begin
          wr_ptr <= wr_ptr + (ADDR_WIDTH + 1)'(1);
          if (state == nts_tx_pkg::BANK_EMPTY) begin
            state <= nts_tx_pkg::BANK_HAS_DATA;
          end
        end
        if (i_parser_cmd.read_en && (state != nts_tx_pkg::BANK_EMPTY)) begin
          read_data <= mem[i_address_hi];
        end
        if (i_parser_cmd.update_length && (state == nts_tx_pkg::BANK_HAS_DATA)) begin
          word_count      <= length_words;
          bytes_last_word <= length_bytes;
        end
        if (i_parser_cmd.done && (state == nts_tx_pkg::BANK_HAS_DATA)) begin
          state <= nts_tx_pkg::BANK_FIFO_OUT;
        end
      end

      // FIFO side
      if (i_dispatch_cmd.start) begin
        rd_ptr <= '0;
      end else if (i_dispatch_cmd.rd_en && (state == nts_tx_pkg::BANK_FIFO_OUT) &&
                   !fifo_empty) begin
        rd_ptr <= rd_ptr + (ADDR_WIDTH + 1)'(1);
      end

      // Release hands the bank back to the parser side as an empty bank
      if (i_dispatch_cmd.packet_read && (state == nts_tx_pkg::BANK_FIFO_OUT)) begin
        state      <= nts_tx_pkg::BANK_EMPTY;
        wr_ptr     <= '0;
        rd_ptr     <= '0;
        word_count <= '0;
      end
    end
  end

  always_comb begin
    o_status.state           = state;
    o_status.full            = full;
    o_status.fifo_empty      = fifo_empty;
    o_status.bytes_last_word = bytes_last_word;
    o_status.fifo_data       = mem[rd_ptr[ADDR_WIDTH-1:0]];
    o_status.read_data       = read_data;
  end

endmodule

`default_nettype wire

// File: src/tx_buffer_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tx_buffer_ctrl #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                          i_clk,
  input  wire                          i_areset,
  input  wire                          i_write_en,
  input  wire [63:0]                   i_write_data,
  input  wire                          i_read_en,
  input  wire                          i_update_length,
  input  wire                          i_parser_done,
  input  wire                          i_parser_clear,
  input  wire                          i_dispatch_tx_fifo_rd_en,
  input  wire                          i_dispatch_tx_packet_read,
  input  wire nts_tx_pkg::bank_status_t i_status0,
  input  wire nts_tx_pkg::bank_status_t i_status1,
  output nts_tx_pkg::parser_cmd_t      o_parser_cmd0,
  output nts_tx_pkg::parser_cmd_t      o_parser_cmd1,
  output nts_tx_pkg::dispatch_cmd_t    o_dispatch_cmd0,
  output nts_tx_pkg::dispatch_cmd_t    o_dispatch_cmd1,
  output logic [63:0]                  o_read_data,
  output logic                         o_error,
  output logic                         o_parser_current_empty,
  output logic                         o_parser_current_memory_full,
  output logic                         o_dispatch_tx_packet_available,
  output logic                         o_dispatch_tx_fifo_empty,
  output logic [63:0]                  o_dispatch_tx_fifo_rd_data,
  output logic [3:0]                   o_dispatch_tx_bytes_last_word
);

  logic                     parser_sel;
  logic                     swap;
  logic                     bad_input;
  nts_tx_pkg::bank_status_t parser_status;
  nts_tx_pkg::bank_status_t fifo_status;
  nts_tx_pkg::parser_cmd_t  parser_cmd;
  nts_tx_pkg::dispatch_cmd_t fifo_cmd;

  //----------------------------------------
  // Role selection and swap
  //----------------------------------------

  assign parser_status = parser_sel ? i_status1 : i_status0;
  assign fifo_status   = parser_sel ? i_status0 : i_status1;

  assign swap = (parser_status.state == nts_tx_pkg::BANK_FIFO_OUT) &&
                (fifo_status.state == nts_tx_pkg::BANK_EMPTY);

  assign bad_input = (parser_status.state == nts_tx_pkg::BANK_EMPTY) &&
                     (i_read_en || i_update_length || i_parser_done);

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      parser_sel <= 1'b0;
      o_error    <= 1'b0;
    end else begin
      if (swap) begin
        parser_sel <= ~parser_sel;
      end
      o_error <= bad_input;
    end
  end

  //----------------------------------------
  // Command routing
  //----------------------------------------

  always_comb begin
    parser_cmd.write_en      = i_write_en;
    parser_cmd.write_data    = i_write_data;
    parser_cmd.read_en       = i_read_en;
    parser_cmd.update_length = i_update_length;
    parser_cmd.done          = i_parser_done;
    parser_cmd.clear         = i_parser_clear;

    fifo_cmd.rd_en       = i_dispatch_tx_fifo_rd_en;
    fifo_cmd.packet_read = i_dispatch_tx_packet_read;
    fifo_cmd.start       = 1'b0;

    o_parser_cmd0   = parser_sel ? '0 : parser_cmd;
    o_parser_cmd1   = parser_sel ? parser_cmd : '0;
    o_dispatch_cmd0 = parser_sel ? fifo_cmd : '0;
    o_dispatch_cmd1 = parser_sel ? '0 : fifo_cmd;

    // Start goes to the parser bank that turns into the FIFO
    o_dispatch_cmd0.start = swap && !parser_sel;
    o_dispatch_cmd1.start = swap && parser_sel;
  end

  // Idle bank always reports zero, so a read survives a swap
  assign o_read_data = i_status0.read_data | i_status1.read_data;

  assign o_parser_current_empty         = parser_status.state == nts_tx_pkg::BANK_EMPTY;
  assign o_parser_current_memory_full   = parser_status.full;
  assign o_dispatch_tx_packet_available = fifo_status.state == nts_tx_pkg::BANK_FIFO_OUT;
  assign o_dispatch_tx_fifo_empty       = fifo_status.fifo_empty;
  assign o_dispatch_tx_fifo_rd_data     = fifo_status.fifo_data;
  assign o_dispatch_tx_bytes_last_word  = fifo_status.bytes_last_word;

endmodule

`default_nettype wire

// File: src/nts_tx_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module nts_tx_buffer #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                  i_clk,
  input  wire                  i_areset,
  // Parser side
  input  wire                  i_write_en,
  input  wire [63:0]           i_write_data,
  input  wire                  i_read_en,
  input  wire [ADDR_WIDTH-1:0] i_address_hi,
  input  wire                  i_update_length,
  input  wire [ADDR_WIDTH+2:0] i_length,
  input  wire                  i_parser_done,
  input  wire                  i_parser_clear,
  // Dispatch side
  input  wire                  i_dispatch_tx_fifo_rd_en,
  input  wire                  i_dispatch_tx_packet_read,
  output wire [63:0]           o_read_data,
  output wire                  o_error,
  output wire                  o_parser_current_empty,
  output wire                  o_parser_current_memory_full,
  output wire                  o_dispatch_tx_packet_available,
  output wire                  o_dispatch_tx_fifo_empty,
  output wire [63:0]           o_dispatch_tx_fifo_rd_data,
  output wire [3:0]            o_dispatch_tx_bytes_last_word
);

  nts_tx_pkg::parser_cmd_t   parser_cmd0;
  nts_tx_pkg::parser_cmd_t   parser_cmd1;
  nts_tx_pkg::dispatch_cmd_t dispatch_cmd0;
  nts_tx_pkg::dispatch_cmd_t dispatch_cmd1;
  nts_tx_pkg::bank_status_t  status0;
  nts_tx_pkg::bank_status_t  status1;

  //----------------------------------------
  // Ping-pong banks
  //----------------------------------------

  tx_bank #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank0 (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_parser_cmd   (parser_cmd0),
    .i_dispatch_cmd (dispatch_cmd0),
    .i_address_hi   (i_address_hi),
    .i_length       (i_length),
    .o_status       (status0)
  );

  tx_bank #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank1 (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_parser_cmd   (parser_cmd1),
    .i_dispatch_cmd (dispatch_cmd1),
    .i_address_hi   (i_address_hi),
    .i_length       (i_length),
    .o_status       (status1)
  );

  //----------------------------------------
  // Role control
  //----------------------------------------

  tx_buffer_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_ctrl (
    .i_clk                          (i_clk),
    .i_areset                       (i_areset),
    .i_write_en                     (i_write_en),
    .i_write_data                   (i_write_data),
    .i_read_en                      (i_read_en),
    .i_update_length                (i_update_length),
    .i_parser_done                  (i_parser_done),
    .i_parser_clear                 (i_parser_clear),
    .i_dispatch_tx_fifo_rd_en       (i_dispatch_tx_fifo_rd_en),
    .i_dispatch_tx_packet_read      (i_dispatch_tx_packet_read),
    .i_status0                      (status0),
    .i_status1                      (status1),
    .o_parser_cmd0                  (parser_cmd0),
    .o_parser_cmd1                  (parser_cmd1),
    .o_dispatch_cmd0                (dispatch_cmd0),
    .o_dispatch_cmd1                (dispatch_cmd1),
    .o_read_data                    (o_read_data),
    .o_error                        (o_error),
    .o_parser_current_empty         (o_parser_current_empty),
    .o_parser_current_memory_full   (o_parser_current_memory_full),
    .o_dispatch_tx_packet_available (o_dispatch_tx_packet_available),
    .o_dispatch_tx_fifo_empty       (o_dispatch_tx_fifo_empty),
    .o_dispatch_tx_fifo_rd_data     (o_dispatch_tx_fifo_rd_data),
    .o_dispatch_tx_bytes_last_word  (o_dispatch_tx_bytes_last_word)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_areset
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
  end

  // Release reset away from the rising edge
  initial begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_areset = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_nts_tx_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_nts_tx_buffer;

  localparam int ADDR_WIDTH = 4;
  localparam int DEPTH      = 2 ** ADDR_WIDTH;
  localparam int CLK_NS     = 100;
  localparam int MAX_LINES  = 256;
  localparam int WAIT_LIMIT = 64;

  typedef logic [8*12-1:0] keyword_t;

  // Strobes driven together in one cycle
  typedef struct packed {
    logic write_en;
    logic read_en;
    logic update_length;
    logic done;
    logic clear;
    logic rd_en;
    logic packet_read;
  } strobe_t;

  localparam keyword_t OP_COMMENT    = keyword_t'("#");
  localparam keyword_t OP_WRITE      = keyword_t'("write");
  localparam keyword_t OP_WRAND      = keyword_t'("wrand");
  localparam keyword_t OP_BURST      = keyword_t'("burst");
  localparam keyword_t OP_READ       = keyword_t'("read");
  localparam keyword_t OP_LENGTH     = keyword_t'("length");
  localparam keyword_t OP_DONE       = keyword_t'("done");
  localparam keyword_t OP_CLEAR      = keyword_t'("clear");
  localparam keyword_t OP_POP        = keyword_t'("pop");
  localparam keyword_t OP_RELEASE    = keyword_t'("release");
  localparam keyword_t OP_IDLE       = keyword_t'("idle");
  localparam keyword_t OP_WAIT_AVAIL = keyword_t'("wait_avail");
  localparam keyword_t OP_EMPTY      = keyword_t'("empty");
  localparam keyword_t OP_FULL       = keyword_t'("full");
  localparam keyword_t OP_AVAIL      = keyword_t'("avail");
  localparam keyword_t OP_FIFO_EMPTY = keyword_t'("fifo_empty");
  localparam keyword_t OP_ERROR      = keyword_t'("error");
  localparam keyword_t OP_BYTES      = keyword_t'("bytes");

  logic                  clk;
  logic                  areset;
  logic                  write_en;
  logic [63:0]           write_data;
  logic                  read_en;
  logic [ADDR_WIDTH-1:0] address_hi;
  logic                  update_length;
  logic [ADDR_WIDTH+2:0] length;
  logic                  parser_done;
  logic                  parser_clear;
  logic                  fifo_rd_en;
  logic                  packet_read;
  logic [63:0]           read_data;
  logic                  error;
  logic                  parser_empty;
  logic                  parser_full;
  logic                  packet_available;
  logic                  fifo_empty;
  logic [63:0]           fifo_rd_data;
  logic [3:0]            bytes_last_word;

  // Golden file contents
  keyword_t    op_mem   [0:MAX_LINES-1];
  logic [63:0] data_mem [0:MAX_LINES-1];
  logic [63:0] exp_mem  [0:MAX_LINES-1];
  int          line_count;
  logic        loaded;

  // Reference model of the two packet queues
  logic [63:0] parser_q[$];
  logic [63:0] dispatch_q[$];
  int          pkt_words_q[$];
  int          pending_words;
  int          seed;

  int word_errors;
  int flag_errors;
  int byte_errors;
  int other_errors;

  tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clock_gen (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_tx_buffer #(.ADDR_WIDTH(ADDR_WIDTH)) i_dut (
    .i_clk                          (clk),
    .i_areset                       (areset),
    .i_write_en                     (write_en),
    .i_write_data                   (write_data),
    .i_read_en                      (read_en),
    .i_address_hi                   (address_hi),
    .i_update_length                (update_length),
    .i_length                       (length),
    .i_parser_done                  (parser_done),
    .i_parser_clear                 (parser_clear),
    .i_dispatch_tx_fifo_rd_en       (fifo_rd_en),
    .i_dispatch_tx_packet_read      (packet_read),
    .o_read_data                    (read_data),
    .o_error                        (error),
    .o_parser_current_empty         (parser_empty),
    .o_parser_current_memory_full   (parser_full),
    .o_dispatch_tx_packet_available (packet_available),
    .o_dispatch_tx_fifo_empty       (fifo_empty),
    .o_dispatch_tx_fifo_rd_data     (fifo_rd_data),
    .o_dispatch_tx_bytes_last_word  (bytes_last_word)
  );

  //----------------------------------------
  // Compare tasks
  //----------------------------------------

  task automatic check_word(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
      word_errors++;
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, actual, expected);
      flag_errors++;
    end
  endtask

  task automatic check_bytes(input logic [3:0] actual, input logic [3:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      byte_errors++;
    end
  endtask

  //----------------------------------------
  // Stimulus helpers
  //----------------------------------------

  function automatic logic [63:0] random_word();
    random_word = {$random(seed), $random(seed)};
  endfunction

  // Strobes pulse for one cycle while data, address and length carry the value
  task automatic drive_strobes(input strobe_t s, input logic [63:0] value);
    @(posedge clk);
    write_en      <= s.write_en;
    read_en       <= s.read_en;
    update_length <= s.update_length;
    parser_done   <= s.done;
    parser_clear  <= s.clear;
    fifo_rd_en    <= s.rd_en;
    packet_read   <= s.packet_read;
    write_data    <= value;
    address_hi    <= value[ADDR_WIDTH-1:0];
    length        <= value[ADDR_WIDTH+2:0];
    @(posedge clk);
    write_en      <= 1'b0;
    read_en       <= 1'b0;
    update_length <= 1'b0;
    parser_done   <= 1'b0;
    parser_clear  <= 1'b0;
    fifo_rd_en    <= 1'b0;
    packet_read   <= 1'b0;
    @(negedge clk);
  endtask

  task automatic write_word(input logic [63:0] word);
    strobe_t s;
    s = '0;
    s.write_en = 1'b1;
    drive_strobes(s, word);
    // Full bank drops the word
    if (parser_q.size() < DEPTH) begin
      parser_q.push_back(word);
    end
  endtask

  task automatic load_golden();
    int       fd;
    int       n;
    int       c;
    logic     at_end;
    keyword_t op;
    logic [63:0] d;
    logic [63:0] e;
    line_count = 0;
    at_end = 1'b0;
    fd = $fopen("testbench/nts_tx_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/nts_tx_golden.txt");
      other_errors++;
      at_end = 1'b1;
    end
    while (!at_end) begin
      n = $fscanf(fd, "%s", op);
      if (n != 1) begin
        at_end = 1'b1;
      end else if (op == OP_COMMENT) begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else begin
        n = $fscanf(fd, "%h %h", d, e);
        if (n != 2 || line_count >= MAX_LINES) begin
          $display("Golden file line after operation %0d could not be read", line_count);
          other_errors++;
          at_end = 1'b1;
        end else begin
          op_mem[line_count]   = op;
          data_mem[line_count] = d;
          exp_mem[line_count]  = e;
          line_count++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
  endtask

  //----------------------------------------
  // Operation decoder
  //----------------------------------------

  task automatic run_op(input keyword_t op, input logic [63:0] value,
                        input logic [63:0] expect_val);
    strobe_t     s;
    logic [63:0] word;
    int          addr;
    int          count;
    int          waited;
    s = '0;
    case (op)
      OP_WRITE: begin
        write_word(value);
      end
      OP_WRAND: begin
        write_word(random_word());
      end
      OP_BURST: begin
        repeat (int'(value[7:0])) write_word(random_word());
      end
      OP_READ: begin
        s.read_en = 1'b1;
        drive_strobes(s, value);
        addr = int'(value[ADDR_WIDTH-1:0]);
        word = (addr < parser_q.size()) ? parser_q[addr] : '0;
        check_word(read_data, word, "parser read-back");
      end
      OP_LENGTH: begin
        s.update_length = 1'b1;
        drive_strobes(s, value);
        if (parser_q.size() > 0) begin
          pending_words = (int'(value[15:0]) + nts_tx_pkg::WORD_BYTES - 1) /
                          nts_tx_pkg::WORD_BYTES;
        end
      end
      OP_DONE: begin
        s.done = 1'b1;
        drive_strobes(s, value);
        if (parser_q.size() > 0) begin
          count = (pending_words < parser_q.size()) ? pending_words : parser_q.size();
          for (int k = 0; k < count; k++) begin
            dispatch_q.push_back(parser_q[k]);
          end
          pkt_words_q.push_back(count);
          parser_q.delete();
          pending_words = 0;
        end
      end
      OP_CLEAR: begin
        s.clear = 1'b1;
        drive_strobes(s, value);
        parser_q.delete();
        pending_words = 0;
      end
      OP_POP: begin
        // First word falls through, so check before the read strobe
        if (pkt_words_q.size() > 0 && pkt_words_q[0] > 0) begin
          check_word(fifo_rd_data, dispatch_q[0], "FIFO word");
          word = dispatch_q.pop_front();
          pkt_words_q[0] = pkt_words_q[0] - 1;
        end
        s.rd_en = 1'b1;
        drive_strobes(s, value);
      end
      OP_RELEASE: begin
        s.packet_read = 1'b1;
        drive_strobes(s, value);
        if (pkt_words_q.size() > 0) begin
          count = pkt_words_q.pop_front();
          for (int k = 0; k < count; k++) begin
            word = dispatch_q.pop_front();
          end
        end
      end
      OP_IDLE: begin
        repeat (int'(value[7:0])) @(posedge clk);
        @(negedge clk);
      end
      OP_WAIT_AVAIL: begin
        waited = 0;
        while (!packet_available && waited < WAIT_LIMIT) begin
          @(negedge clk);
          waited++;
        end
        if (!packet_available) begin
          $display("Packet never became available within %0d cycles", WAIT_LIMIT);
          other_errors++;
        end
      end
      OP_EMPTY:      check_flag(parser_empty, expect_val[0], "parser bank empty");
      OP_FULL:       check_flag(parser_full, expect_val[0], "parser bank full");
      OP_AVAIL:      check_flag(packet_available, expect_val[0], "packet available");
      OP_FIFO_EMPTY: check_flag(fifo_empty, expect_val[0], "FIFO empty");
      OP_ERROR:      check_flag(error, expect_val[0], "error pulse");
      OP_BYTES:      check_bytes(bytes_last_word, expect_val[3:0], "bytes in last word");
      default: begin
        $display("Golden file holds an unknown operation");
        other_errors++;
      end
    endcase
  endtask

  //----------------------------------------
  // Main sequence and watchdog
  //----------------------------------------

  initial begin
    write_en      = 1'b0;
    write_data    = '0;
    read_en       = 1'b0;
    address_hi    = '0;
    update_length = 1'b0;
    length        = '0;
    parser_done   = 1'b0;
    parser_clear  = 1'b0;
    fifo_rd_en    = 1'b0;
    packet_read   = 1'b0;
    loaded        = 1'b0;
    pending_words = 0;
    word_errors   = 0;
    flag_errors   = 0;
    byte_errors   = 0;
    other_errors  = 0;
    seed          = 32'h6d830e33;
    load_golden();
    loaded = 1'b1;
    wait (areset == 1'b0);
    @(negedge clk);
    for (int i = 0; i < line_count; i++) begin
      run_op(op_mem[i], data_mem[i], exp_mem[i]);
    end
    $display("Errors: word %0d, flag %0d, bytes %0d, other %0d",
             word_errors, flag_errors, byte_errors, other_errors);
    if (word_errors + flag_errors + byte_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #(longint'(line_count + 50) * CLK_NS * 20);
    $display("Watchdog expired before the golden operations completed");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
src/nts_tx_pkg.sv
src/tx_bank.sv
src/tx_buffer_ctrl.sv
src/nts_tx_buffer.sv
testbench/tb_clock_gen.sv
testbench/tb_nts_tx_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module tb_nts_tx_buffer -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -qx "Verification passed" sim.log && echo "Run OK" \
  || { echo "Run FAILED, see sim.log"; exit 1; }

// File: testbench/nts_tx_golden.txt
# operation  data, address or length (hex)  expected value (hex)
# wrand and burst take their words from the seeded random source
empty 0 1
avail 0 0
error 0 0
write 0123456789abcdef 0
write fedcba9876543210 0
wrand 0 0
wrand 0 0
wrand 0 0
empty 0 0
read 0 0
read 1 0
read 2 0
read 3 0
read 4 0
length 25 0
done 0 0
wait_avail 0 0
bytes 0 5
fifo_empty 0 0
# second packet fills while the first one is held
burst 5 0
length 28 0
done 0 0
empty 0 0
full 0 1
pop 0 0
pop 0 0
pop 0 0
pop 0 0
fifo_empty 0 0
pop 0 0
fifo_empty 0 1
idle 4 0
avail 0 1
bytes 0 5
release 0 0
avail 0 0
wait_avail 0 0
bytes 0 8
fifo_empty 0 0
pop 0 0
pop 0 0
pop 0 0
pop 0 0
pop 0 0
fifo_empty 0 1
release 0 0
avail 0 0
# fill one bank to the top, then clear it
empty 0 1
burst 10 0
full 0 1
wrand 0 0
read f 0
clear 0 0
empty 0 1
full 0 0
# commands while the parser bank is empty
read 3 0
error 0 1
idle 1 0
error 0 0
length 10 0
error 0 1
idle 1 0
error 0 0
